//--- verilog/udp_echo_pkg.sv
/*
 * Shared types and constants for the UDP echo engine.
 * Every module refers to these by scoped name. The defaults here
 * feed the top-level parameters.
 */
package udp_echo_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;

    // Header fields handed from the parser to the reply builder
    typedef struct packed {
        mac_addr_t dest_mac;
        mac_addr_t src_mac;
        ip_addr_t  src_ip;
        ip_addr_t  dest_ip;
        port_t     src_port;
        port_t     dest_port;
        port_t     udp_length;
    } udp_hdr_t;

    // 14 Ethernet + 20 IPv4 + 8 UDP
    localparam int HDR_BYTES = 42;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam byte_t       IP_PROTO_UDP   = 8'd17;
    localparam byte_t       IP_VER_IHL     = 8'h45;
    localparam byte_t       REPLY_TTL      = 8'd64;

    // Board defaults
    localparam mac_addr_t DEFAULT_LOCAL_MAC = 48'h02_00_00_00_00_00;
    localparam ip_addr_t  DEFAULT_LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam port_t     DEFAULT_ECHO_PORT = 16'd1234;

    // Must be a power of two
    localparam int DEFAULT_FIFO_DEPTH = 64;

endpackage

//--- verilog/axis_byte_if.sv
/*
 * Byte-wide stream with valid/ready handshake, frame end and error bit.
 * Used for the payload links between the blocks of the echo engine.
 */
`timescale 1ns/100ps

interface axis_byte_if;

    udp_echo_pkg::byte_t tdata;
    logic                tvalid;
    logic                tready;
    logic                tlast;
    logic                tuser;

    modport source (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

endinterface

//--- verilog/udp_frame_parser.sv
/*
 * Receive-side parser. Collects the 42 Ethernet/IPv4/UDP header bytes,
 * checks type, version/IHL and protocol, offers the header fields and
 * then forwards the payload bytes unchanged until the end of the frame.
 */
`timescale 1ns/100ps

module udp_frame_parser (
    input  logic                   clk_125mhz,
    input  logic                   rst_125mhz,
    input  udp_echo_pkg::byte_t    rx_tdata,
    input  logic                   rx_tvalid,
    input  logic                   rx_tlast,
    input  logic                   rx_tuser,
    output logic                   rx_tready,
    output logic                   hdr_valid,
    input  logic                   hdr_ready,
    output udp_echo_pkg::udp_hdr_t hdr,
    axis_byte_if.source            pl
);

    localparam int HDR_BITS = udp_echo_pkg::HDR_BYTES * 8;

    typedef enum logic [1:0] {ST_HEADER, ST_HOLD, ST_PAYLOAD, ST_DROP} state_t;

    state_t              state;
    logic [5:0]          byte_cnt;
    logic [HDR_BITS-1:0] hdr_shift;
    logic [HDR_BITS-1:0] hdr_next;
    logic                rx_xfer;
    logic                hdr_ok;

    assign rx_xfer  = rx_tvalid && rx_tready;
    assign hdr_next = {hdr_shift[HDR_BITS-9:0], rx_tdata};

    // Byte 0 sits at the top. Ethertype at 12, version/IHL at 14, protocol at 23
    assign hdr_ok = (hdr_next[239:224] == udp_echo_pkg::ETHERTYPE_IPV4) &&
                    (hdr_next[223:216] == udp_echo_pkg::IP_VER_IHL) &&
                    (hdr_next[151:144] == udp_echo_pkg::IP_PROTO_UDP);

    always_ff @(posedge clk_125mhz) begin
        if (rx_xfer && state == ST_HEADER) begin
            hdr_shift <= hdr_next;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state    <= ST_HEADER;
            byte_cnt <= '0;
        end else begin
            case (state)
                ST_HEADER: begin
                    if (rx_xfer) begin
                        byte_cnt <= byte_cnt + 6'd1;
                        if (rx_tlast) begin
                            // Frame too short to carry a payload
                            byte_cnt <= '0;
                        end else if (byte_cnt == 6'(udp_echo_pkg::HDR_BYTES - 1)) begin
                            byte_cnt <= '0;
                            state    <= hdr_ok ? ST_HOLD : ST_DROP;
                        end
                    end
                end
                ST_HOLD: begin
                    if (hdr_ready) begin
                        state <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD, ST_DROP: begin
                    if (rx_xfer && rx_tlast) begin
                        state <= ST_HEADER;
                    end
                end
                default: state <= ST_HEADER;
            endcase
        end
    end

    always_comb begin
        rx_tready = 1'b1;
        pl.tvalid = 1'b0;
        case (state)
            ST_HOLD:    rx_tready = 1'b0;
            ST_PAYLOAD: begin
                rx_tready = pl.tready;
                pl.tvalid = rx_tvalid;
            end
            default:    rx_tready = 1'b1;
        endcase
    end

    assign pl.tdata = rx_tdata;
    assign pl.tlast = rx_tlast;
    assign pl.tuser = rx_tuser;

    assign hdr_valid      = (state == ST_HOLD);
    assign hdr.dest_mac   = hdr_shift[335:288];
    assign hdr.src_mac    = hdr_shift[287:240];
    assign hdr.src_ip     = hdr_shift[127:96];
    assign hdr.dest_ip    = hdr_shift[95:64];
    assign hdr.src_port   = hdr_shift[63:48];
    assign hdr.dest_port  = hdr_shift[47:32];
    assign hdr.udp_length = hdr_shift[31:16];

endmodule

//--- verilog/echo_port_filter.sv
/*
 * Per-frame echo decision. Headers for the echo port go on to the
 * reply builder, and their payload goes into the FIFO. Anything else
 * is accepted at once and thrown away up to its last byte.
 */
`timescale 1ns/100ps

module echo_port_filter #(
    parameter udp_echo_pkg::port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT
) (
    input  logic                   clk_125mhz,
    input  logic                   rst_125mhz,
    input  logic                   in_hdr_valid,
    output logic                   in_hdr_ready,
    input  udp_echo_pkg::udp_hdr_t in_hdr,
    output logic                   out_hdr_valid,
    input  logic                   out_hdr_ready,
    output udp_echo_pkg::udp_hdr_t out_hdr,
    axis_byte_if.sink              pl_in,
    axis_byte_if.source            pl_out
);

    typedef enum logic [1:0] {DEC_NONE, DEC_ECHO, DEC_DROP} decision_t;

    decision_t decision;
    logic      match;

    assign match = (in_hdr.dest_port == ECHO_PORT);

    assign out_hdr_valid = in_hdr_valid && match;
    assign in_hdr_ready  = (out_hdr_ready && match) || !match;
    assign out_hdr       = in_hdr;

    // Held from the header transfer until the payload's final byte
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            decision <= DEC_NONE;
        end else if (in_hdr_valid && in_hdr_ready) begin
            decision <= match ? DEC_ECHO : DEC_DROP;
        end else if (pl_in.tvalid && pl_in.tready && pl_in.tlast) begin
            decision <= DEC_NONE;
        end
    end

    assign pl_out.tdata  = pl_in.tdata;
    assign pl_out.tlast  = pl_in.tlast;
    assign pl_out.tuser  = pl_in.tuser;
    assign pl_out.tvalid = pl_in.tvalid && (decision == DEC_ECHO);

    // Dropped payload is sunk at full rate
    assign pl_in.tready = (pl_out.tready && decision == DEC_ECHO) || (decision == DEC_DROP);

endmodule

//--- verilog/payload_fifo.sv
/*
 * Synchronous byte FIFO holding the echoed payload with its last and
 * user bits. Read data comes straight from the memory, so a written
 * byte shows on the read side one cycle after the write.
 */
`timescale 1ns/100ps

module payload_fifo #(
    parameter int DEPTH = udp_echo_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic        clk_125mhz,
    input  logic        rst_125mhz,
    axis_byte_if.sink   wr,
    axis_byte_if.source rd
);

    localparam int AW = $clog2(DEPTH);

    // Entry is {tuser, tlast, tdata}
    logic [9:0]  mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    always_ff @(posedge clk_125mhz) begin
        if (wr.tvalid && wr.tready) begin
            mem[wr_ptr[AW-1:0]] <= {wr.tuser, wr.tlast, wr.tdata};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.tvalid && wr.tready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd.tvalid && rd.tready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign wr.tready = !full;
    assign rd.tvalid = !empty;
    assign {rd.tuser, rd.tlast, rd.tdata} = mem[rd_ptr[AW-1:0]];

endmodule

//--- verilog/udp_reply_builder.sv
/*
 * Reply transmitter. Takes an accepted header, builds the swapped
 * Ethernet/IPv4/UDP reply header with its IP checksum, sends its 42
 * bytes in network order and then streams the payload from the FIFO.
 * The first payload byte of every reply is latched onto the LEDs.
 */
`timescale 1ns/100ps

module udp_reply_builder #(
    parameter udp_echo_pkg::mac_addr_t LOCAL_MAC = udp_echo_pkg::DEFAULT_LOCAL_MAC,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP  = udp_echo_pkg::DEFAULT_LOCAL_IP
) (
    input  logic                   clk_125mhz,
    input  logic                   rst_125mhz,
    input  logic                   hdr_valid,
    output logic                   hdr_ready,
    input  udp_echo_pkg::udp_hdr_t hdr,
    axis_byte_if.sink              pl,
    output udp_echo_pkg::byte_t    tx_tdata,
    output logic                   tx_tvalid,
    output logic                   tx_tlast,
    output logic                   tx_tuser,
    input  logic                   tx_tready,
    output udp_echo_pkg::byte_t    led
);

    localparam int HDR_BITS = udp_echo_pkg::HDR_BYTES * 8;

    typedef enum logic [1:0] {ST_IDLE, ST_HEADER, ST_PAYLOAD} state_t;

    state_t              state;
    logic [5:0]          byte_cnt;
    logic [HDR_BITS-1:0] tx_shift;
    logic [HDR_BITS-1:0] reply_hdr;
    logic [15:0]         total_len;
    logic [19:0]         csum_sum;
    logic [16:0]         csum_fold;
    logic [15:0]         ip_csum;
    logic                first_pending;

    assign total_len = hdr.udp_length + 16'd20;

    // Identification, flags and the checksum field itself add nothing
    assign csum_sum = {udp_echo_pkg::IP_VER_IHL, 8'h00} + total_len +
                      {udp_echo_pkg::REPLY_TTL, udp_echo_pkg::IP_PROTO_UDP} +
                      LOCAL_IP[31:16] + LOCAL_IP[15:0] +
                      hdr.src_ip[31:16] + hdr.src_ip[15:0];
    assign csum_fold = csum_sum[15:0] + csum_sum[19:16];
    assign ip_csum   = ~(csum_fold[15:0] + 16'(csum_fold[16]));

    assign reply_hdr = {
        hdr.src_mac, LOCAL_MAC, udp_echo_pkg::ETHERTYPE_IPV4,
        udp_echo_pkg::IP_VER_IHL, 8'h00, total_len, 16'h0000, 16'h0000,
        udp_echo_pkg::REPLY_TTL, udp_echo_pkg::IP_PROTO_UDP, ip_csum,
        LOCAL_IP, hdr.src_ip,
        hdr.dest_port, hdr.src_port, hdr.udp_length, 16'h0000
    };

    assign hdr_ready = (state == ST_IDLE);

    always_ff @(posedge clk_125mhz) begin
        if (hdr_valid && hdr_ready) begin
            tx_shift <= reply_hdr;
        end else if (state == ST_HEADER && tx_tready) begin
            tx_shift <= {tx_shift[HDR_BITS-9:0], 8'h00};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state         <= ST_IDLE;
            byte_cnt      <= '0;
            first_pending <= 1'b0;
            led           <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_valid) begin
                        state         <= ST_HEADER;
                        byte_cnt      <= '0;
                        first_pending <= 1'b1;
                    end
                end
                ST_HEADER: begin
                    if (tx_tready) begin
                        byte_cnt <= byte_cnt + 6'd1;
                        if (byte_cnt == 6'(udp_echo_pkg::HDR_BYTES - 1)) begin
                            state <= ST_PAYLOAD;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (pl.tvalid && tx_tready) begin
                        if (first_pending) begin
                            led           <= pl.tdata;
                            first_pending <= 1'b0;
                        end
                        if (pl.tlast) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        tx_tdata  = tx_shift[HDR_BITS-1 -: 8];
        tx_tvalid = 1'b0;
        tx_tlast  = 1'b0;
        tx_tuser  = 1'b0;
        pl.tready = 1'b0;
        case (state)
            ST_HEADER:  tx_tvalid = 1'b1;
            ST_PAYLOAD: begin
                tx_tdata  = pl.tdata;
                tx_tvalid = pl.tvalid;
                tx_tlast  = pl.tlast;
                tx_tuser  = pl.tuser;
                pl.tready = tx_tready;
            end
            default:    tx_tvalid = 1'b0;
        endcase
    end

endmodule

//--- verilog/udp_echo_core.sv
/*
 * UDP echo engine top level. Sits between the MAC receive and transmit
 * byte streams and answers frames sent to the echo port.
 */
`timescale 1ns/100ps

module udp_echo_core #(
    parameter udp_echo_pkg::mac_addr_t LOCAL_MAC  = udp_echo_pkg::DEFAULT_LOCAL_MAC,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP   = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter udp_echo_pkg::port_t     ECHO_PORT  = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter int                      FIFO_DEPTH = udp_echo_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                clk_125mhz,
    input  logic                rst_125mhz,
    input  udp_echo_pkg::byte_t rx_tdata,
    input  logic                rx_tvalid,
    output logic                rx_tready,
    input  logic                rx_tlast,
    input  logic                rx_tuser,
    output udp_echo_pkg::byte_t tx_tdata,
    output logic                tx_tvalid,
    input  logic                tx_tready,
    output logic                tx_tlast,
    output logic                tx_tuser,
    output udp_echo_pkg::byte_t led
);

    logic                   rx_hdr_valid;
    logic                   rx_hdr_ready;
    udp_echo_pkg::udp_hdr_t rx_hdr;
    logic                   echo_hdr_valid;
    logic                   echo_hdr_ready;
    udp_echo_pkg::udp_hdr_t echo_hdr;

    axis_byte_if parser_pl ();
    axis_byte_if fifo_in ();
    axis_byte_if fifo_out ();

    udp_frame_parser parser_inst (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .rx_tdata(rx_tdata), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast),
        .rx_tuser(rx_tuser), .rx_tready(rx_tready),
        .hdr_valid(rx_hdr_valid), .hdr_ready(rx_hdr_ready), .hdr(rx_hdr),
        .pl(parser_pl.source)
    );

    echo_port_filter #(.ECHO_PORT(ECHO_PORT)) filter_inst (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .in_hdr_valid(rx_hdr_valid), .in_hdr_ready(rx_hdr_ready), .in_hdr(rx_hdr),
        .out_hdr_valid(echo_hdr_valid), .out_hdr_ready(echo_hdr_ready),
        .out_hdr(echo_hdr),
        .pl_in(parser_pl.sink), .pl_out(fifo_in.source)
    );

    payload_fifo #(.DEPTH(FIFO_DEPTH)) fifo_inst (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .wr(fifo_in.sink), .rd(fifo_out.source)
    );

    udp_reply_builder #(.LOCAL_MAC(LOCAL_MAC), .LOCAL_IP(LOCAL_IP)) builder_inst (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .hdr_valid(echo_hdr_valid), .hdr_ready(echo_hdr_ready), .hdr(echo_hdr),
        .pl(fifo_out.sink),
        .tx_tdata(tx_tdata), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast),
        .tx_tuser(tx_tuser), .tx_tready(tx_tready), .led(led)
    );

endmodule

//--- tests/udp_echo_props.sv
/*
 * Concurrent assertions on the echo engine's transmit stream and LEDs.
 * Bound into the top level, so every instance of it is covered.
 */
`timescale 1ns/100ps

module udp_echo_props (
    input logic                clk_125mhz,
    input logic                rst_125mhz,
    input udp_echo_pkg::byte_t tx_tdata,
    input logic                tx_tvalid,
    input logic                tx_tready,
    input udp_echo_pkg::byte_t led
);

    // A stalled byte stays on the bus unchanged
    assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata))
        else $error("tx byte changed or was withdrawn while stalled");

    assert property (@(posedge clk_125mhz) rst_125mhz |=> !tx_tvalid)
        else $error("tx_tvalid high while in reset");

    // LED only moves on a transmit transfer
    assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        !(tx_tvalid && tx_tready) |=> $stable(led))
        else $error("led changed without a tx transfer");

endmodule

bind udp_echo_core udp_echo_props props_inst (
    .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz), .tx_tdata(tx_tdata),
    .tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .led(led)
);

//--- tests/udp_echo_tb.sv
/*
 * Testbench for the UDP echo engine. Sends random Ethernet/IPv4/UDP frames
 * with valid gaps, stalls the transmit side at random, and checks every reply
 * byte and the LED output against a model of the echo rules.
 */
`timescale 1ns/100ps

module udp_echo_tb;

    localparam int          NUM_FRAMES  = 40;
    localparam int          MAX_PAYLOAD = 32;
    localparam int          TIMEOUT_CYCLES =
        NUM_FRAMES * (udp_echo_pkg::HDR_BYTES + MAX_PAYLOAD) * 4 + 1000;
    localparam logic [31:0] SEED = 32'hd74e_6453;

    logic                clk_125mhz;
    logic                rst_125mhz;
    udp_echo_pkg::byte_t rx_tdata;
    logic                rx_tvalid;
    logic                rx_tready;
    logic                rx_tlast;
    logic                rx_tuser;
    udp_echo_pkg::byte_t tx_tdata;
    logic                tx_tvalid;
    logic                tx_tready;
    logic                tx_tlast;
    logic                tx_tuser;
    udp_echo_pkg::byte_t led;

    // Expected tx bytes as {first payload byte, tuser, tlast, tdata}
    logic [10:0]         exp_q[$];
    udp_echo_pkg::byte_t led_q[$];
    logic [31:0]         frame_rng;
    logic [31:0]         stall_rng;
    int                  errors;
    int                  checks;
    int                  reply_errors;
    int                  reply_bytes;
    int                  replies_seen;
    int                  replies_expected;
    int                  frames_dropped;
    int                  cycle_count;
    logic                led_check_due;
    logic                reply_done_due;
    udp_echo_pkg::byte_t led_expected;

    // Small FIFO so that long payloads fill it and hold off rx
    udp_echo_core #(.FIFO_DEPTH(16)) uut (
        .clk_125mhz(clk_125mhz), .rst_125mhz(rst_125mhz),
        .rx_tdata(rx_tdata), .rx_tvalid(rx_tvalid), .rx_tready(rx_tready),
        .rx_tlast(rx_tlast), .rx_tuser(rx_tuser),
        .tx_tdata(tx_tdata), .tx_tvalid(tx_tvalid), .tx_tready(tx_tready),
        .tx_tlast(tx_tlast), .tx_tuser(tx_tuser), .led(led)
    );

    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_frame_rand();
        frame_rng = xorshift32(frame_rng);
        return frame_rng;
    endfunction

    // Folded and inverted ones'-complement sum of the ten header words
    function automatic logic [15:0] ip_checksum(input logic [159:0] ip_hdr);
        logic [31:0] sum;
        sum = '0;
        for (int w = 0; w < 10; w++) begin
            sum = sum + {16'h0000, ip_hdr[159 - 16*w -: 16]};
        end
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        return ~sum[15:0];
    endfunction

    task automatic check_byte(input string name, input udp_echo_pkg::byte_t exp_data,
                              input logic exp_last, input logic exp_user,
                              input udp_echo_pkg::byte_t act_data,
                              input logic act_last, input logic act_user);
        checks++;
        if (exp_data !== act_data || exp_last !== act_last || exp_user !== act_user) begin
            $display({"error %s: expected 8'h%02h last %0b user %0b, ",
                      "actual 8'h%02h last %0b user %0b"},
                     name, exp_data, exp_last, exp_user, act_data, act_last, act_user);
            errors++;
            reply_errors++;
        end
    endtask

    task automatic check_led(input string name, input udp_echo_pkg::byte_t exp_led,
                             input udp_echo_pkg::byte_t act_led);
        checks++;
        if (exp_led !== act_led) begin
            $display("error %s: expected 8'h%02h, actual 8'h%02h", name, exp_led, act_led);
            errors++;
            reply_errors++;
        end
    endtask

    // One byte on rx with a random idle gap in front
    task automatic send_byte(input udp_echo_pkg::byte_t data, input logic last,
                             input logic user);
        logic [31:0] r;
        logic        accepted;
        r = next_frame_rand();
        while (r[1:0] == 2'd0) begin
            rx_tvalid = 1'b0;
            @(posedge clk_125mhz);
            #1;
            r = next_frame_rand();
        end
        rx_tdata  = data;
        rx_tvalid = 1'b1;
        rx_tlast  = last;
        rx_tuser  = user;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk_125mhz);
            accepted = rx_tready;
            @(posedge clk_125mhz);
            #1;
        end
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
        rx_tuser  = 1'b0;
    endtask

    task automatic send_frame();
        udp_echo_pkg::byte_t     payload[$];
        udp_echo_pkg::mac_addr_t src_mac;
        udp_echo_pkg::ip_addr_t  src_ip;
        udp_echo_pkg::port_t     src_port;
        udp_echo_pkg::port_t     dest_port;
        udp_echo_pkg::port_t     udp_len;
        logic [15:0]             eth_type;
        udp_echo_pkg::byte_t     proto;
        logic [335:0]            rx_bits;
        logic [335:0]            reply_bits;
        logic [31:0]             r;
        logic [31:0]             r2;
        logic                    last_user;
        int                      len;
        r = next_frame_rand();
        src_mac[47:32] = r[15:0];
        src_mac[31:0]  = next_frame_rand();
        src_ip         = next_frame_rand();
        r = next_frame_rand();
        src_port  = r[15:0];
        dest_port = r[16] ? udp_echo_pkg::DEFAULT_ECHO_PORT : {1'b1, r[31:17]};
        r = next_frame_rand();
        eth_type = 16'h0800;
        proto    = 8'd17;
        if (r[2:0] == 3'd0) begin
            if (r[3]) eth_type = 16'h0806;
            else proto = 8'd6;
        end
        len       = 1 + int'(r[8:4]);
        last_user = (r[11:9] == 3'd0);
        udp_len   = 16'(8 + len);
        for (int i = 0; i < len; i++) begin
            r2 = next_frame_rand();
            payload.push_back(r2[7:0]);
        end
        r2 = next_frame_rand();
        rx_bits = {udp_echo_pkg::DEFAULT_LOCAL_MAC, src_mac, eth_type, 8'h45, 8'h00,
                   udp_len + 16'd20, r[31:16], 16'h4000, r2[7:0], proto, r2[31:16],
                   src_ip, udp_echo_pkg::DEFAULT_LOCAL_IP, src_port, dest_port,
                   udp_len, r2[23:8]};
        if (eth_type == 16'h0800 && proto == 8'd17 && dest_port == 16'd1234) begin
            // Swapped addresses and ports, TTL 64, zero UDP checksum
            reply_bits = {src_mac, udp_echo_pkg::DEFAULT_LOCAL_MAC, 16'h0800, 8'h45, 8'h00,
                          udp_len + 16'd20, 16'h0000, 16'h0000, 8'd64, 8'd17, 16'h0000,
                          udp_echo_pkg::DEFAULT_LOCAL_IP, src_ip, dest_port, src_port,
                          udp_len, 16'h0000};
            reply_bits[143:128] = ip_checksum(reply_bits[223:64]);
            for (int k = 0; k < 42; k++) begin
                exp_q.push_back({3'b000, reply_bits[335 - 8*k -: 8]});
            end
            for (int i = 0; i < len; i++) begin
                exp_q.push_back({(i == 0), (i == len - 1) && last_user, (i == len - 1),
                                 payload[i]});
            end
            led_q.push_back(payload[0]);
            replies_expected++;
        end else begin
            frames_dropped++;
        end
        for (int k = 0; k < 42; k++) begin
            send_byte(rx_bits[335 - 8*k -: 8], 1'b0, 1'b0);
        end
        for (int i = 0; i < len; i++) begin
            send_byte(payload[i], (i == len - 1), (i == len - 1) && last_user);
        end
    endtask

    initial begin
        tx_tready = 1'b0;
        stall_rng = SEED ^ 32'h3c5a_96e1;
        forever begin
            @(posedge clk_125mhz);
            #1;
            stall_rng = xorshift32(stall_rng);
            tx_tready = (stall_rng[1:0] != 2'd0);
        end
    end

    // Transmit monitor sampled mid-cycle where everything has settled
    always @(negedge clk_125mhz) begin
        logic [10:0] e;
        if (!rst_125mhz) begin
            if (led_check_due) begin
                check_led($sformatf("reply_%0d led", replies_seen), led_expected, led);
                led_check_due = 1'b0;
            end
            if (reply_done_due) begin
                $display("test reply_%0d: %0d bytes, %0d errors",
                         replies_seen, reply_bytes, reply_errors);
                replies_seen++;
                reply_bytes    = 0;
                reply_errors   = 0;
                reply_done_due = 1'b0;
            end
            if (tx_tvalid && tx_tready) begin
                if (exp_q.size() == 0) begin
                    $display("tx byte 8'h%02h was sent while no reply was expected", tx_tdata);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    reply_bytes++;
                    check_byte($sformatf("reply_%0d byte %0d", replies_seen, reply_bytes - 1),
                               e[7:0], e[8], e[9], tx_tdata, tx_tlast, tx_tuser);
                    if (e[10]) begin
                        led_expected  = led_q.pop_front();
                        led_check_due = 1'b1;
                    end
                    if (e[8]) reply_done_due = 1'b1;
                end
            end
        end
    end

    always @(posedge clk_125mhz) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d replies received",
                     cycle_count, replies_seen, replies_expected);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rst_125mhz = 1'b1;
        rx_tdata = '0;
        rx_tvalid = 1'b0;
        rx_tlast = 1'b0;
        rx_tuser = 1'b0;
        frame_rng = SEED;
        errors = 0;
        checks = 0;
        reply_errors = 0;
        reply_bytes = 0;
        replies_seen = 0;
        replies_expected = 0;
        frames_dropped = 0;
        cycle_count = 0;
        led_check_due = 1'b0;
        reply_done_due = 1'b0;
        repeat (4) @(posedge clk_125mhz);
        #1;
        rst_125mhz = 1'b0;
        check_led("reset led", 8'h00, led);
        $display("test reset: led 8'h%02h, %0d errors", led, errors);
        reply_errors = 0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            send_frame();
        end
        while (replies_seen < replies_expected) @(posedge clk_125mhz);
        // Quiet window to catch stray bytes after the last reply
        repeat (50) @(posedge clk_125mhz);
        if (exp_q.size() != 0 || led_q.size() != 0) begin
            $display("%0d expected reply bytes were never sent", exp_q.size());
            errors++;
        end
        $display("frames %0d, replies %0d, dropped %0d, checks %0d, errors %0d",
                 NUM_FRAMES, replies_seen, frames_dropped, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- udp_echo_core.f
verilog/udp_echo_pkg.sv
verilog/axis_byte_if.sv
verilog/udp_frame_parser.sv
verilog/echo_port_filter.sv
verilog/payload_fifo.sv
verilog/udp_reply_builder.sv
verilog/udp_echo_core.sv
tests/udp_echo_props.sv
tests/udp_echo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the echo engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module udp_echo_tb \
    -f udp_echo_core.f -o udp_echo_sim || exit 1
out=$(./obj_dir/udp_echo_sim)
echo "$out"
echo "$out" | grep -qF "Simulation finished: PASS" && echo "run passed" \
    || { echo "run failed"; exit 1; }
